// File: verilog/pau_settings.svh
////////////////////////////////////////////////////////////////////////////
// Width and size settings for the pointer authentication unit.
// Include this file in every module that sizes a port or register from
// these values; the include guard makes repeated inclusion harmless.
////////////////////////////////////////////////////////////////////////////

`ifndef PAU_SETTINGS_SVH
`define PAU_SETTINGS_SVH

// pointer and context width
`define PAU_PTR_W 32

// upper pointer bits that carry the tag
`define PAU_TAG_W 8

// number of 128-bit key slots
`define PAU_KEY_SLOTS 2

`endif

// File: verilog/pau_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the pointer authentication unit: the request opcode
// and the state encoding of the mixing core.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package pau_pkg;

  // request opcode
  typedef enum logic {
    PAU_OP_SIGN = 1'b0,  // insert tag into upper pointer bits
    PAU_OP_AUTH = 1'b1   // check tag, return stripped pointer
  } pau_op_e;

  // mixing core states, one round per cycle
  typedef enum logic [2:0] {
    PAU_CS_INPUT  = 3'd0,
    PAU_CS_ROUND1 = 3'd1,
    PAU_CS_ROUND2 = 3'd2,
    PAU_CS_ROUND3 = 3'd3,
    PAU_CS_OUTPUT = 3'd4
  } pau_cipher_state_e;

endpackage

`default_nettype wire

// File: verilog/pau_decode.sv
////////////////////////////////////////////////////////////////////////////
// Request front end: key slot storage, cipher block formation and the
// per-request state that the result stage needs once the tag is ready.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pau_settings.svh"

module pau_decode import pau_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // request
  input  logic                               req_valid_i,
  input  pau_op_e                            req_op_i,
  input  logic [$clog2(`PAU_KEY_SLOTS)-1:0]  req_key_slot_i,
  input  logic [`PAU_PTR_W-1:0]              req_ptr_i,
  input  logic [`PAU_PTR_W-1:0]              req_ctx_i,
  output logic                               req_ready_o,
  // key write
  input  logic                               key_we_i,
  input  logic [$clog2(`PAU_KEY_SLOTS)-1:0]  key_slot_i,
  input  logic [1:0]                         key_word_i,
  input  logic [31:0]                        key_wdata_i,
  // cipher input side
  output logic                               blk_valid_o,
  output logic [2*`PAU_PTR_W-1:0]            blk_data_o,
  output logic [127:0]                       blk_key_o,
  input  logic                               blk_ready_i,
  // state for the result stage
  output pau_op_e                            op_o,
  output logic [`PAU_TAG_W-1:0]              tag_in_o,
  output logic [`PAU_PTR_W-1:0]              ptr_o
);

  logic [127:0]            key_q [`PAU_KEY_SLOTS];
  logic [`PAU_PTR_W-1:0]   ptr_stripped;
  logic                    req_accept;
  pau_op_e                 op_q;
  logic [`PAU_TAG_W-1:0]   tag_in_q;
  logic [`PAU_PTR_W-1:0]   ptr_q;

  // canonical pointer has zero upper bits
  assign ptr_stripped = {{`PAU_TAG_W{1'b0}}, req_ptr_i[`PAU_PTR_W-`PAU_TAG_W-1:0]};

  assign req_ready_o = blk_ready_i;                // cipher is the only slot
  assign req_accept  = req_valid_i & blk_ready_i;

  assign blk_valid_o = req_valid_i;
  assign blk_data_o  = {req_ctx_i, ptr_stripped};  // context above pointer
  assign blk_key_o   = key_q[req_key_slot_i];

  // one 32-bit word per strobe, word 0 is least significant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `PAU_KEY_SLOTS; i++) begin
        key_q[i] <= '0;
      end
    end else if (key_we_i) begin
      key_q[key_slot_i][key_word_i*32 +: 32] <= key_wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      op_q <= PAU_OP_SIGN;
    end else if (req_accept) begin
      op_q <= req_op_i;
    end
  end

  // incoming tag and stripped pointer, held until the next accept
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      tag_in_q <= req_ptr_i[`PAU_PTR_W-1 -: `PAU_TAG_W];
      ptr_q    <= ptr_stripped;
    end
  end

  assign op_o     = op_q;
  assign tag_in_o = tag_in_q;
  assign ptr_o    = ptr_q;

  a_key_slot_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    key_we_i |-> (int'(key_slot_i) < `PAU_KEY_SLOTS)
  );

endmodule

`default_nettype wire

// File: verilog/pau_cipher.sv
////////////////////////////////////////////////////////////////////////////
// Keyed mixing core. Captures a 64-bit block and a 128-bit key on the
// input handshake, runs three XOR rounds and presents the folded 32-bit
// word until the output handshake completes. Handles one block at a time.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pau_settings.svh"

module pau_cipher import pau_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [127:0]              key_i,
  input  logic [2*`PAU_PTR_W-1:0]   in_data_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  output logic [`PAU_PTR_W-1:0]     out_data_o,
  output logic                      out_valid_o,
  input  logic                      out_ready_i
);

  pau_cipher_state_e        state_q, state_d;
  logic [127:0]             key_q, key_d;
  logic [2*`PAU_PTR_W-1:0]  data_q, data_d;

  always_comb begin
    state_d     = state_q;
    key_d       = key_q;
    data_d      = data_q;
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    out_data_o  = '0;

    unique case (state_q)
      PAU_CS_INPUT: begin
        in_ready_o = 1'b1;
        if (in_valid_i) begin
          data_d  = in_data_i;  // block and key captured together
          key_d   = key_i;
          state_d = PAU_CS_ROUND1;
        end
      end

      PAU_CS_ROUND1: begin
        data_d  = data_q ^ key_q[63:0];
        state_d = PAU_CS_ROUND2;
      end

      PAU_CS_ROUND2: begin
        data_d  = data_q ^ key_q[127:64];
        state_d = PAU_CS_ROUND3;
      end

      PAU_CS_ROUND3: begin
        data_d  = data_q ^ key_q[63:0];
        state_d = PAU_CS_OUTPUT;
      end

      PAU_CS_OUTPUT: begin
        // fold the two halves into one word
        out_data_o  = data_q[`PAU_PTR_W-1:0] ^ data_q[2*`PAU_PTR_W-1:`PAU_PTR_W];
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          state_d = PAU_CS_INPUT;
        end
      end

      default: begin
        state_d = PAU_CS_INPUT;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= PAU_CS_INPUT;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    key_q  <= key_d;
    data_q <= data_d;
  end

  // result must not move while the consumer stalls
  a_out_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == PAU_CS_OUTPUT && !out_ready_i)
      |=> (state_q == PAU_CS_OUTPUT && $stable(out_data_o))
  );

  // output rises four edges after its accept and nothing else gets accepted meanwhile
  a_single_slot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !$past(out_valid_o))
      |-> ($past(in_valid_i && in_ready_o, 4) &&
           !$past(in_ready_o, 1) && !$past(in_ready_o, 2) && !$past(in_ready_o, 3))
  );

endmodule

`default_nettype wire

// File: verilog/pau_result.sv
////////////////////////////////////////////////////////////////////////////
// Response stage: inserts the tag for sign, checks and strips it for
// authenticate, and counts authenticate faults on completed responses.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pau_settings.svh"

module pau_result import pau_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // request state from decode
  input  pau_op_e                 op_i,
  input  logic [`PAU_TAG_W-1:0]   tag_in_i,
  input  logic [`PAU_PTR_W-1:0]   ptr_i,
  // cipher output side
  input  logic [`PAU_PTR_W-1:0]   cipher_data_i,
  input  logic                    cipher_valid_i,
  output logic                    cipher_ready_o,
  // response
  input  logic                    rsp_ready_i,
  output logic                    rsp_valid_o,
  output logic [`PAU_PTR_W-1:0]   rsp_ptr_o,
  output logic                    rsp_fault_o,
  output logic [7:0]              fault_count_o
);

  logic [`PAU_TAG_W-1:0]  tag;
  logic                   tag_mismatch;
  logic                   rsp_done;
  logic [7:0]             fault_cnt_q;

  assign tag          = cipher_data_i[`PAU_TAG_W-1:0];  // low bits of folded word
  assign tag_mismatch = (tag != tag_in_i);

  assign rsp_valid_o    = cipher_valid_i;
  assign cipher_ready_o = rsp_ready_i;
  assign rsp_done       = cipher_valid_i & rsp_ready_i;

  always_comb begin
    if (op_i == PAU_OP_SIGN) begin
      rsp_ptr_o = {tag, ptr_i[`PAU_PTR_W-`PAU_TAG_W-1:0]};
    end else begin
      rsp_ptr_o = ptr_i;  // already stripped in decode
    end
  end

  assign rsp_fault_o = cipher_valid_i & (op_i == PAU_OP_AUTH) & tag_mismatch;

  // saturating count of faulting authenticates
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fault_cnt_q <= '0;
    end else if (rsp_done && rsp_fault_o && fault_cnt_q != 8'hff) begin
      fault_cnt_q <= fault_cnt_q + 8'd1;
    end
  end

  assign fault_count_o = fault_cnt_q;

  // a completed sign response never moves the fault count
  a_no_sign_fault : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rsp_done && op_i == PAU_OP_SIGN) |=> (fault_cnt_q == $past(fault_cnt_q))
  );

endmodule

`default_nettype wire

// File: verilog/pau_top.sv
////////////////////////////////////////////////////////////////////////////
// Pointer authentication unit top level. Connects the request decode,
// the mixing core and the response stage to the core-facing ports.
// Response is valid in the fourth cycle after a request is accepted.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pau_settings.svh"

module pau_top import pau_pkg::*; (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  // request
  input  logic                               req_valid_i,
  input  pau_op_e                            req_op_i,
  input  logic [$clog2(`PAU_KEY_SLOTS)-1:0]  req_key_slot_i,
  input  logic [`PAU_PTR_W-1:0]              req_ptr_i,
  input  logic [`PAU_PTR_W-1:0]              req_ctx_i,
  output logic                               req_ready_o,
  // key write
  input  logic                               key_we_i,
  input  logic [$clog2(`PAU_KEY_SLOTS)-1:0]  key_slot_i,
  input  logic [1:0]                         key_word_i,
  input  logic [31:0]                        key_wdata_i,
  // response
  input  logic                               rsp_ready_i,
  output logic                               rsp_valid_o,
  output logic [`PAU_PTR_W-1:0]              rsp_ptr_o,
  output logic                               rsp_fault_o,
  output logic [7:0]                         fault_count_o
);

  logic                     blk_valid;
  logic                     blk_ready;
  logic [2*`PAU_PTR_W-1:0]  blk_data;
  logic [127:0]             blk_key;
  pau_op_e                  op_q;
  logic [`PAU_TAG_W-1:0]    tag_in_q;
  logic [`PAU_PTR_W-1:0]    ptr_q;
  logic                     out_valid;
  logic                     out_ready;
  logic [`PAU_PTR_W-1:0]    out_data;

  pau_decode pau_decode_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_op_i       (req_op_i),
    .req_key_slot_i (req_key_slot_i),
    .req_ptr_i      (req_ptr_i),
    .req_ctx_i      (req_ctx_i),
    .req_ready_o    (req_ready_o),
    .key_we_i       (key_we_i),
    .key_slot_i     (key_slot_i),
    .key_word_i     (key_word_i),
    .key_wdata_i    (key_wdata_i),
    .blk_valid_o    (blk_valid),
    .blk_data_o     (blk_data),
    .blk_key_o      (blk_key),
    .blk_ready_i    (blk_ready),
    .op_o           (op_q),
    .tag_in_o       (tag_in_q),
    .ptr_o          (ptr_q)
  );

  pau_cipher pau_cipher_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .key_i       (blk_key),
    .in_data_i   (blk_data),
    .in_valid_i  (blk_valid),
    .in_ready_o  (blk_ready),
    .out_data_o  (out_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready)
  );

  pau_result pau_result_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .op_i           (op_q),
    .tag_in_i       (tag_in_q),
    .ptr_i          (ptr_q),
    .cipher_data_i  (out_data),
    .cipher_valid_i (out_valid),
    .cipher_ready_o (out_ready),
    .rsp_ready_i    (rsp_ready_i),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_ptr_o      (rsp_ptr_o),
    .rsp_fault_o    (rsp_fault_o),
    .fault_count_o  (fault_count_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source: clock period of 40 time units and
// an active-low reset held for the first 5 clock cycles.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;  // half period
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // release away from the active edge
  end

endmodule

`default_nettype wire

// File: sim/tb_pau_top.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the pointer authentication unit. Drives sign, authenticate
// and key writes on falling edges, predicts every response from the cipher
// rule and checks each completed response in a separate compare process.
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pau_settings.svh"

module tb_pau_top import pau_pkg::*; ();

  typedef logic [$clog2(`PAU_KEY_SLOTS)-1:0] slot_t;

  localparam int WAIT_LIMIT = 40;
  localparam int N_PTR      = 6;

  logic                   clk, rst_n;
  logic                   req_valid, req_ready, key_we;
  pau_op_e                req_op;
  slot_t                  req_slot, key_slot;
  logic [`PAU_PTR_W-1:0]  req_ptr, req_ctx, rsp_ptr;
  logic [1:0]             key_word;
  logic [31:0]            key_wdata;
  logic                   rsp_ready, rsp_valid, rsp_fault;
  logic [7:0]             fault_count;

  logic [127:0]           key_model [`PAU_KEY_SLOTS];
  logic [31:0]            exp_ptr_q[$];
  logic                   exp_fault_q[$];
  logic [31:0]            seed = 32'hc92b_ccec;
  int                     checks, errors, exp_faults;
  logic [31:0]            sp_ptr [N_PTR];  // signed pointers kept for later tests
  logic [31:0]            sp_ctx [N_PTR];
  slot_t                  sp_slot [N_PTR];

  tb_clock_gen tb_clock_gen_inst (.clk_o(clk), .rst_no(rst_n));

  pau_top pau_top_inst (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .req_valid_i    (req_valid),
    .req_op_i       (req_op),
    .req_key_slot_i (req_slot),
    .req_ptr_i      (req_ptr),
    .req_ctx_i      (req_ctx),
    .req_ready_o    (req_ready),
    .key_we_i       (key_we),
    .key_slot_i     (key_slot),
    .key_word_i     (key_word),
    .key_wdata_i    (key_wdata),
    .rsp_ready_i    (rsp_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_ptr_o      (rsp_ptr),
    .rsp_fault_o    (rsp_fault),
    .fault_count_o  (fault_count)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  function automatic logic [31:0] strip(input logic [31:0] ptr);
    logic [31:0] s;
    s = ptr;
    s[`PAU_PTR_W-1 -: `PAU_TAG_W] = '0;
    return s;
  endfunction

  // three XOR rounds over {ctx, stripped ptr}, then fold to one word
  function automatic logic [`PAU_TAG_W-1:0] ref_tag(input logic [127:0] key,
                                                     input logic [31:0] ptr,
                                                     input logic [31:0] ctx);
    logic [63:0] blk;
    logic [31:0] word;
    blk  = {ctx, strip(ptr)};
    blk  = blk ^ key[63:0];
    blk  = blk ^ key[127:64];
    blk  = blk ^ key[63:0];
    word = blk[31:0] ^ blk[63:32];
    return word[`PAU_TAG_W-1:0];
  endfunction

  function automatic logic predict_fault(input slot_t slot, input logic [31:0] ptr,
                                         input logic [31:0] ctx);
    return ref_tag(key_model[slot], ptr, ctx) != ptr[`PAU_PTR_W-1 -: `PAU_TAG_W];
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  task automatic timed_out(input string what);
    errors++;
    $display("timeout at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s finished with %0d errors", name, errors - errs_before);
  endtask

  task automatic write_key(input slot_t slot, input logic [1:0] word,
                           input logic [31:0] data);
    @(negedge clk);
    key_we    = 1'b1;
    key_slot  = slot;
    key_word  = word;
    key_wdata = data;
    key_model[slot][word*32 +: 32] = data;
    @(negedge clk);
    key_we = 1'b0;
  endtask

  // one request through to its completed response, with optional stall
  task automatic do_op(input pau_op_e op, input slot_t slot, input logic [31:0] ptr,
                       input logic [31:0] ctx, input int hold, input bit mid_write,
                       output logic [31:0] got, output logic fault);
    logic [31:0] r;
    int          cycles;
    cycles = 0;
    @(negedge clk);
    while (!req_ready) begin
      cycles++;
      if (cycles > WAIT_LIMIT) timed_out("req_ready_o");
      @(negedge clk);
    end
    if (op == PAU_OP_SIGN) begin
      exp_ptr_q.push_back({ref_tag(key_model[slot], ptr, ctx),
                           ptr[`PAU_PTR_W-`PAU_TAG_W-1:0]});
      exp_fault_q.push_back(1'b0);
    end else begin
      exp_ptr_q.push_back(strip(ptr));
      exp_fault_q.push_back(predict_fault(slot, ptr, ctx));
    end
    req_valid = 1'b1;
    req_op    = op;
    req_slot  = slot;
    req_ptr   = ptr;
    req_ctx   = ctx;
    rsp_ready = (hold == 0);
    cycles    = 0;
    do begin
      @(negedge clk);
      req_valid = 1'b0;
      cycles++;
      key_we = mid_write && cycles == 1;  // lands in the first round
      if (key_we) begin
        r         = next_rand();
        key_slot  = slot;
        key_word  = r[1:0];
        key_wdata = next_rand();
        key_model[slot][key_word*32 +: 32] = key_wdata;
      end
      if (cycles > WAIT_LIMIT) timed_out("rsp_valid_o");
    end while (!rsp_valid);
    check_value("response latency", cycles, 4);
    got   = rsp_ptr;
    fault = rsp_fault;
    repeat (hold) begin
      @(negedge clk);
      check_value("rsp_valid_o under stall", 32'(rsp_valid), 1);
      check_value("rsp_ptr_o under stall", rsp_ptr, got);
      check_value("req_ready_o under stall", 32'(req_ready), 0);
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    check_value("rsp_valid_o after handshake", 32'(rsp_valid), 0);
    check_value("req_ready_o after handshake", 32'(req_ready), 1);
    check_value("outstanding responses", exp_ptr_q.size(), 0);
    check_value("fault_count_o", 32'(fault_count), exp_faults);
  endtask

  // every completed response is matched against the oldest prediction
  initial begin
    forever begin
      @(posedge clk);
      if (rst_n && rsp_valid && rsp_ready) begin
        if (exp_ptr_q.size() == 0) begin
          errors++;
          $display("response at %0t arrived with no request outstanding", $time);
        end else begin
          check_value("rsp_ptr_o", rsp_ptr, exp_ptr_q.pop_front());
          if (exp_fault_q[0] && exp_faults < 255) exp_faults++;
          check_value("rsp_fault_o", 32'(rsp_fault), 32'(exp_fault_q.pop_front()));
        end
      end
    end
  end

  initial begin
    logic [31:0] got, p, c, r;
    logic        fault;
    logic [7:0]  count_before;
    slot_t       s;
    int          faults, errs, wait_cnt;
    req_valid = 1'b0;
    req_op    = PAU_OP_SIGN;
    req_slot  = '0;
    req_ptr   = '0;
    req_ctx   = '0;
    key_we    = 1'b0;
    key_slot  = '0;
    key_word  = '0;
    key_wdata = '0;
    rsp_ready = 1'b1;
    for (int i = 0; i < `PAU_KEY_SLOTS; i++) key_model[i] = '0;
    wait_cnt = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      wait_cnt++;
      if (wait_cnt > WAIT_LIMIT) timed_out("reset release");
    end

    errs = errors;
    @(negedge clk);
    check_value("req_ready_o after reset", 32'(req_ready), 1);
    check_value("rsp_valid_o after reset", 32'(rsp_valid), 0);
    check_value("rsp_fault_o after reset", 32'(rsp_fault), 0);
    check_value("fault_count_o after reset", 32'(fault_count), 0);
    report_test("test 1 reset state", errs);

    errs = errors;
    for (int sl = 0; sl < `PAU_KEY_SLOTS; sl++) begin
      for (int w = 0; w < 4; w++) write_key(slot_t'(sl), 2'(w), next_rand());
    end
    for (int i = 0; i < N_PTR; i++) begin
      sp_slot[i] = slot_t'(i % `PAU_KEY_SLOTS);
      sp_ctx[i]  = next_rand();
      do_op(PAU_OP_SIGN, sp_slot[i], next_rand(), sp_ctx[i], 0, 1'b0, sp_ptr[i], fault);
    end
    report_test("test 2 sign with random keys", errs);

    errs = errors;
    for (int i = 0; i < N_PTR; i++) begin
      do_op(PAU_OP_AUTH, sp_slot[i], sp_ptr[i], sp_ctx[i], 0, 1'b0, got, fault);
      check_value("authenticated pointer", got, strip(sp_ptr[i]));
      check_value("fault on genuine pointer", 32'(fault), 0);
    end
    report_test("test 3 sign then authenticate", errs);

    errs = errors;
    count_before = fault_count;
    faults = 0;
    for (int i = 0; i < N_PTR; i++) begin
      for (int k = 0; k < 3; k++) begin
        p = sp_ptr[i];
        c = sp_ctx[i];
        s = sp_slot[i];
        r = next_rand();
        if (k == 0) begin
          p = p ^ (32'h8000_0000 >> r[2:0]);  // one tag bit flipped
        end else if (k == 1) begin
          c = c ^ (r | 32'h1);
        end else begin
          s = ~s;
        end
        faults += int'(predict_fault(s, p, c));
        do_op(PAU_OP_AUTH, s, p, c, 0, 1'b0, got, fault);
        check_value("tampered pointer stripped", got, strip(p));
      end
    end
    check_value("fault count rise", 32'(fault_count) - 32'(count_before), faults);
    report_test("test 4 tampered authenticate", errs);

    errs = errors;
    for (int i = 0; i < 4; i++) begin
      do_op((i % 2 == 0) ? PAU_OP_SIGN : PAU_OP_AUTH, sp_slot[i], sp_ptr[i], sp_ctx[i],
            1 + int'(next_rand() % 32'd8), 1'b0, got, fault);
    end
    report_test("test 5 back-pressure", errs);

    errs = errors;
    for (int sl = 0; sl < `PAU_KEY_SLOTS; sl++) begin
      p = next_rand();
      c = next_rand();
      do_op(PAU_OP_SIGN, slot_t'(sl), p, c, 0, 1'b1, got, fault);  // key changes mid-run
      do_op(PAU_OP_SIGN, slot_t'(sl), p, c, 0, 1'b0, got, fault);
    end
    report_test("test 6 key write during computation", errs);

    finish_run();
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/pau_pkg.sv
verilog/pau_decode.sv
verilog/pau_cipher.sv
verilog/pau_result.sv
verilog/pau_top.sv
sim/tb_clock_gen.sv
sim/tb_pau_top.sv

// File: Makefile
# Verilator build for the pointer authentication unit.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
FILE_LIST ?= files.f
TB_TOP    ?= tb_pau_top
RTL_TOP   ?= pau_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

$(BUILD_DIR)/V$(TB_TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
